//--- tests/fpu_trace.txt
# op a b result iv, all hex; ops 0-2 sgnj/n/x, 3 min, 4 max, 5 feq, 6 flt, 7 fle, 8 class
# classify and illegal ops ignore b
00 3F800000 BF800000 BF800000 0
01 3F800000 3F800000 BF800000 0
01 7FC00001 BF800000 7FC00001 0
02 BF800000 BF800000 3F800000 0
02 80000000 00000000 80000000 0
00 7F800001 80000000 FF800001 0
05 3F800000 3F800000 00000001 0
05 00000000 80000000 00000001 0
05 7FC00000 3F800000 00000000 0
05 7F800001 3F800000 00000000 1
06 BF800000 3F800000 00000001 0
06 C0000000 BF800000 00000001 0
06 80000000 00000000 00000000 0
06 3F800000 7FC00000 00000000 1
07 80000000 00000000 00000001 0
07 40000000 3F800000 00000000 0
07 7FC00000 7FC00000 00000000 1
03 3F800000 40000000 3F800000 0
04 3F800000 40000000 40000000 0
03 00000000 80000000 80000000 0
03 7FC00000 BF800000 BF800000 0
04 7F800001 3F800000 3F800000 1
03 7FC00000 7F800001 7FC00000 1
04 7FC00000 7FC00000 7FC00000 0
08 FF800000 00000000 00000001 0
08 BF800000 00000000 00000002 0
08 807FFFFF 00000000 00000004 0
08 80000000 00000000 00000008 0
08 00000000 00000000 00000010 0
08 00000001 00000000 00000020 0
08 3F800000 00000000 00000040 0
08 7F800000 00000000 00000080 0
08 7F800001 00000000 00000100 0
08 7FC00000 00000000 00000200 0
09 3F800000 3F800000 00000000 1
1F 40000000 3F800000 00000000 1

//--- files.f
+incdir+include
source/fpu_pkg.sv
source/fp_unpack.sv
source/fp_sign_inject.sv
source/fp_compare.sv
source/fp_minmax.sv
source/fp_classify.sv
source/fpu_core.sv
tests/tb_fpu_core.sv

//--- Bender.yml
package:
  name: fpu_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/fpu_pkg.sv
      - source/fp_unpack.sv
      - source/fp_sign_inject.sv
      - source/fp_compare.sv
      - source/fp_minmax.sv
      - source/fp_classify.sv
      - source/fpu_core.sv

  - target: test
    files:
      - tests/tb_fpu_core.sv

//--- tests/tb_fpu_core.sv
`timescale 1ns/1ps

`include "fpu_defs.svh"

module tb_fpu_core import fpu_pkg::*;
();

	logic		clk;
	logic		rst;
	logic		valid_in;
	logic		ready_out;
	fpu_req_t	req;
	logic		valid_out;
	logic		ready_in;
	fpu_resp_t	resp;

	fpu_req_t	req_list[$];
	fpu_resp_t	exp_list[$];
	fpu_resp_t	exp_q[$];

	integer		seed;
	integer		bp_seed;
	int			num_vec;
	int			checked;
	int			cycles;
	int			limit;

	fpu_core fpu_core_inst
	(
		.clk(clk),
		.rst(rst),
		.valid_in(valid_in),
		.ready_out(ready_out),
		.req(req),
		.valid_out(valid_out),
		.ready_in(ready_in),
		.resp(resp)
	);

	always #10 clk = ~clk;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "run aborted");
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
			input string what);
		if (got !== expected) begin
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, expected);
			$display("Simulation failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic load_trace();
		int				fd;
		int				rc;
		string			line;
		logic	[31:0]	op_v;
		logic	[31:0]	a_v;
		logic	[31:0]	b_v;
		logic	[31:0]	r_v;
		logic	[31:0]	iv_v;
		fpu_req_t		r;
		fpu_resp_t		e;
		fd = $fopen("tests/fpu_trace.txt", "r");
		if (fd == 0)
			abort_run("could not open the trace file tests/fpu_trace.txt");
		while (!$feof(fd)) begin
			line = "";
			rc = $fgets(line, fd);
			// comment and blank lines do not scan as five numbers
			if (rc > 0 &&
					$sscanf(line, "%h %h %h %h %h", op_v, a_v, b_v, r_v, iv_v) == 5) begin
				r.op = op_v[4:0];
				r.a = a_v;
				r.b = b_v;
				e.result = r_v;
				e.iv = iv_v[0];
				req_list.push_back(r);
				exp_list.push_back(e);
				// min and max do not depend on operand order, so send the mirror too
				if (r.op == `FPU_OP_MIN || r.op == `FPU_OP_MAX) begin
					r.a = b_v;
					r.b = a_v;
					req_list.push_back(r);
					exp_list.push_back(e);
				end
			end
		end
		$fclose(fd);
		num_vec = req_list.size();
		if (num_vec == 0)
			abort_run("the trace file holds no test vectors");
	endtask

	// accepted on the edge after a negedge that sees ready_out high
	task automatic send_request(input fpu_req_t r, input fpu_resp_t e);
		logic accepted;
		req = r;
		valid_in = 1'b1;
		do begin
			@(negedge clk);
			accepted = ready_out;
			if (accepted)
				exp_q.push_back(e);
			@(posedge clk);
			#1;
		end while (!accepted);
		valid_in = 1'b0;
	endtask

	// random back-pressure, ready about three cycles in four
	always @(posedge clk) begin
		#1;
		ready_in = ($unsigned($random(bp_seed)) % 4) != 0;
	end

	// output side, sampled mid-cycle where everything is settled
	always @(negedge clk) begin
		fpu_resp_t e;
		if (!rst && valid_out && ready_in) begin
			if (exp_q.size() == 0)
				abort_run("the DUT returned a result that no request asked for");
			e = exp_q.pop_front();
			check_value(resp.result, e.result, $sformatf("result of vector %0d", checked));
			check_value({31'b0, resp.iv}, {31'b0, e.iv}, $sformatf("iv of vector %0d", checked));
			checked++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (limit != 0 && cycles >= limit)
			abort_run($sformatf("timeout after %0d cycles, %0d of %0d vectors checked",
				cycles, checked, num_vec));
	end

	initial begin
		int gap;
		clk = 1'b0;
		rst = 1'b1;
		valid_in = 1'b0;
		ready_in = 1'b0;
		req = '0;
		seed = 70;
		bp_seed = seed * 7 + 1;
		checked = 0;
		cycles = 0;
		limit = 0;

		load_trace();
		limit = 8 * num_vec + 100;

		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;

		for (int i = 0; i < num_vec; i++) begin
			gap = $unsigned($random(seed)) % 3;
			repeat (gap) begin
				@(posedge clk);
				#1;
			end
			send_request(req_list[i], exp_list[i]);
		end

		wait (checked == num_vec);
		@(negedge clk);
		if (exp_q.size() == 0 && !valid_out) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			abort_run("results left over after all vectors were checked");
		end
	end

endmodule

//--- source/fpu_core.sv
`timescale 1ns/1ps

`include "fpu_defs.svh"

module fpu_core import fpu_pkg::*;
(
	input	logic		clk,
	input	logic		rst,

	input	logic		valid_in,
	output	logic		ready_out,
	input	fpu_req_t	req,

	output	logic		valid_out,
	input	logic		ready_in,
	output	fpu_resp_t	resp
);

	fpu_req_t		s1_req;
	logic			s1_valid;
	logic			s1_advance;
	logic			s2_load;

	fp_class_t		cls_a;
	fp_class_t		cls_b;
	fp_operand_t	opnd_a;
	fp_operand_t	opnd_b;

	fpu_resp_t		resp_sgnj;
	fpu_resp_t		resp_cmp;
	fpu_resp_t		resp_mm;
	fpu_resp_t		resp_cls;
	fpu_resp_t		resp_sel;

	// stage 2 takes new data when empty or draining
	assign s2_load		= ~valid_out | ready_in;
	assign s1_advance	= s1_valid & s2_load;
	assign ready_out	= ~s1_valid | s1_advance;

	// stage 1, request
	always_ff @(posedge clk) begin
		if (rst)
			s1_valid <= 1'b0;
		else if (ready_out)
			s1_valid <= valid_in;
	end

	always_ff @(posedge clk) begin
		if (ready_out && valid_in)
			s1_req <= req;
	end

	fp_unpack unpack_a (.word(s1_req.a), .cls(cls_a));
	fp_unpack unpack_b (.word(s1_req.b), .cls(cls_b));

	assign opnd_a = {s1_req.a, cls_a};
	assign opnd_b = {s1_req.b, cls_b};

	fp_sign_inject sign_inject_inst
	(
		.op(s1_req.op),
		.a(s1_req.a),
		.sgn_b(s1_req.b.fields.sgn),
		.resp(resp_sgnj)
	);

	fp_compare compare_inst
	(
		.op(s1_req.op),
		.a(opnd_a),
		.b(opnd_b),
		.resp(resp_cmp)
	);

	fp_minmax minmax_inst
	(
		.op(s1_req.op),
		.a(opnd_a),
		.b(opnd_b),
		.resp(resp_mm)
	);

	fp_classify classify_inst
	(
		.a(opnd_a),
		.resp(resp_cls)
	);

	always_comb begin
		case (s1_req.op)
			`FPU_OP_SGNJ, `FPU_OP_SGNJN, `FPU_OP_SGNJX:
				resp_sel = resp_sgnj;
			`FPU_OP_MIN, `FPU_OP_MAX:
				resp_sel = resp_mm;
			`FPU_OP_FEQ, `FPU_OP_FLT, `FPU_OP_FLE:
				resp_sel = resp_cmp;
			`FPU_OP_CLASS:
				resp_sel = resp_cls;
			// illegal op
			default: begin
				resp_sel.result	= '0;
				resp_sel.iv		= 1'b1;
			end
		endcase
	end

	// stage 2, response
	always_ff @(posedge clk) begin
		if (rst)
			valid_out <= 1'b0;
		else if (s2_load)
			valid_out <= s1_valid;
	end

	always_ff @(posedge clk) begin
		if (s1_advance)
			resp <= resp_sel;
	end

	assert property (@(posedge clk) disable iff (rst)
		valid_out && !ready_in |=> valid_out && $stable(resp))
		else $error("response changed while stalled");

	// a request behind a stalled output must still be in stage 1 next cycle
	assert property (@(posedge clk) disable iff (rst)
		s1_valid && valid_out && !ready_in |=> s1_valid && $stable(s1_req))
		else $error("stage 1 dropped a request under back-pressure");

endmodule

//--- source/fp_classify.sv
`timescale 1ns/1ps

module fp_classify import fpu_pkg::*;
(
	input	fp_operand_t	a,
	output	fpu_resp_t		resp
);

	logic			sgn;
	logic			normal;
	logic	[9:0]	mask;

	assign sgn		= a.word.fields.sgn;

	// normal is whatever the unpacker did not flag
	assign normal	= ~(a.cls.zero | a.cls.inf | a.cls.denormal |
						a.cls.snan | a.cls.qnan);

	always_comb begin
		mask[0]	= sgn & a.cls.inf;
		mask[1]	= sgn & normal;
		mask[2]	= sgn & a.cls.denormal;
		mask[3]	= sgn & a.cls.zero;
		mask[4]	= ~sgn & a.cls.zero;
		mask[5]	= ~sgn & a.cls.denormal;
		mask[6]	= ~sgn & normal;
		mask[7]	= ~sgn & a.cls.inf;

		// NaN sign is ignored
		mask[8]	= a.cls.snan;
		mask[9]	= a.cls.qnan;
	end

	assign resp.result	= {22'b0, mask};
	assign resp.iv		= 1'b0;

	always_comb begin
		assert final ($onehot(mask))
			else $error("class mask is not one-hot");
	end

endmodule

//--- source/fp_minmax.sv
`timescale 1ns/1ps

`include "fpu_defs.svh"

module fp_minmax import fpu_pkg::*;
(
	input	logic	[`FPU_OP_W-1:0]	op,
	input	fp_operand_t			a,
	input	fp_operand_t			b,
	output	fpu_resp_t				resp
);

	logic			a_nan;
	logic			b_nan;
	logic			a_lt_b;
	logic	[30:0]	mag_a;
	logic	[30:0]	mag_b;

	assign a_nan	= a.cls.snan | a.cls.qnan;
	assign b_nan	= b.cls.snan | b.cls.qnan;

	assign mag_a	= a.word.bits[30:0];
	assign mag_b	= b.word.bits[30:0];

	// plain sign-magnitude order, so -0 sorts below +0
	always_comb begin
		if (a.word.fields.sgn != b.word.fields.sgn)
			a_lt_b = a.word.fields.sgn;
		else if (!a.word.fields.sgn)
			a_lt_b = mag_a < mag_b;
		else
			a_lt_b = mag_a > mag_b;
	end

	always_comb begin
		if (a_nan && b_nan)
			resp.result = `FPU_CANON_NAN;
		else if (a_nan)
			resp.result = b.word.bits;
		else if (b_nan)
			resp.result = a.word.bits;
		else if (op == `FPU_OP_MIN)
			resp.result = a_lt_b ? a.word.bits : b.word.bits;
		else
			resp.result = a_lt_b ? b.word.bits : a.word.bits;
	end

	// quiet NaN inputs do not signal here
	assign resp.iv = a.cls.snan | b.cls.snan;

endmodule

//--- source/fp_compare.sv
`timescale 1ns/1ps

`include "fpu_defs.svh"

module fp_compare import fpu_pkg::*;
(
	input	logic	[`FPU_OP_W-1:0]	op,
	input	fp_operand_t			a,
	input	fp_operand_t			b,
	output	fpu_resp_t				resp
);

	logic			a_nan;
	logic			b_nan;
	logic			any_nan;
	logic			any_snan;
	logic			both_zero;
	logic			eq;
	logic			lt;
	logic	[30:0]	mag_a;
	logic	[30:0]	mag_b;

	assign a_nan		= a.cls.snan | a.cls.qnan;
	assign b_nan		= b.cls.snan | b.cls.qnan;
	assign any_nan		= a_nan | b_nan;
	assign any_snan		= a.cls.snan | b.cls.snan;

	assign mag_a		= a.word.bits[30:0];
	assign mag_b		= b.word.bits[30:0];

	// +0 and -0 compare equal
	assign both_zero	= a.cls.zero & b.cls.zero;
	assign eq			= both_zero | (a.word.bits == b.word.bits);

	// sign-magnitude order
	always_comb begin
		if (both_zero)
			lt = 1'b0;
		else if (a.word.fields.sgn != b.word.fields.sgn)
			lt = a.word.fields.sgn;
		else if (!a.word.fields.sgn)
			lt = mag_a < mag_b;
		else
			lt = mag_a > mag_b;
	end

	always_comb begin
		resp.result	= '0;
		resp.iv		= 1'b0;

		case (op)
			`FPU_OP_FEQ: begin
				resp.result[0]	= eq & ~any_nan;
				resp.iv			= any_snan;
			end

			// ordered compares signal on quiet NaN as well
			`FPU_OP_FLT: begin
				resp.result[0]	= lt & ~any_nan;
				resp.iv			= any_nan;
			end

			`FPU_OP_FLE: begin
				resp.result[0]	= (lt | eq) & ~any_nan;
				resp.iv			= any_nan;
			end

			default: begin
				resp.result	= '0;
				resp.iv		= 1'b0;
			end
		endcase
	end

	// NaN taken from the raw words, not from the class flags
	always_comb begin
		assert final (!resp.iv ||
				(&a.word.fields.exp && |a.word.fields.man) ||
				(&b.word.fields.exp && |b.word.fields.man))
			else $error("compare raised invalid without a NaN operand");
	end

endmodule

//--- source/fp_sign_inject.sv
`timescale 1ns/1ps

`include "fpu_defs.svh"

module fp_sign_inject import fpu_pkg::*;
(
	input	logic	[`FPU_OP_W-1:0]	op,
	input	fp_word_u				a,
	input	logic					sgn_b,
	output	fpu_resp_t				resp
);

	fp_word_u	res;

	// magnitude of a is kept as is, NaN payload included
	always_comb begin
		res = a;

		case (op)
			`FPU_OP_SGNJ: begin
				res.fields.sgn = sgn_b;
			end

			`FPU_OP_SGNJN: begin
				res.fields.sgn = ~sgn_b;
			end

			`FPU_OP_SGNJX: begin
				res.fields.sgn = a.fields.sgn ^ sgn_b;
			end

			default: begin
				res.fields.sgn = a.fields.sgn;
			end
		endcase
	end

	// sign injection never signals
	assign resp.result	= res.bits;
	assign resp.iv		= 1'b0;

endmodule

//--- source/fp_unpack.sv
`timescale 1ns/1ps

module fp_unpack import fpu_pkg::*;
(
	input	fp_word_u	word,
	output	fp_class_t	cls
);

	logic	exp_max;
	logic	exp_min;
	logic	man_zero;
	logic	quiet_bit;

	assign exp_max		= &word.fields.exp;
	assign exp_min		= ~|word.fields.exp;
	assign man_zero		= ~|word.fields.man;

	// top mantissa bit tells quiet from signaling
	assign quiet_bit	= word.fields.man[22];

	always_comb begin
		cls.zero		= exp_min & man_zero;
		cls.denormal	= exp_min & ~man_zero;
		cls.inf			= exp_max & man_zero;
		cls.snan		= exp_max & ~man_zero & ~quiet_bit;
		cls.qnan		= exp_max & quiet_bit;
	end

endmodule

//--- source/fpu_pkg.sv
`include "fpu_defs.svh"

package fpu_pkg;

	// single precision layout
	typedef struct packed {
		logic			sgn;
		logic	[7:0]	exp;
		logic	[22:0]	man;
	} fp32_fields_t;

	// same word, as fields or as raw bits
	typedef union packed {
		fp32_fields_t	fields;
		logic	[31:0]	bits;
	} fp_word_u;

	// at most one flag set, none for a normal number
	typedef struct packed {
		logic	zero;
		logic	inf;
		logic	denormal;
		logic	snan;
		logic	qnan;
	} fp_class_t;

	// operand after unpacking
	typedef struct packed {
		fp_word_u	word;
		fp_class_t	cls;
	} fp_operand_t;

	// request into the core
	typedef struct packed {
		logic	[`FPU_OP_W-1:0]	op;
		fp_word_u				a;
		fp_word_u				b;
	} fpu_req_t;

	// response out of each unit and out of the core
	typedef struct packed {
		logic	[31:0]	result;
		logic			iv;
	} fpu_resp_t;

endpackage

//--- include/fpu_defs.svh
`ifndef FPU_DEFS_SVH
`define FPU_DEFS_SVH

// op field width
`define FPU_OP_W		5

// sign injection
`define FPU_OP_SGNJ		5'd0
`define FPU_OP_SGNJN	5'd1
`define FPU_OP_SGNJX	5'd2

// selection
`define FPU_OP_MIN		5'd3
`define FPU_OP_MAX		5'd4

// comparison, result is 0 or 1
`define FPU_OP_FEQ		5'd5
`define FPU_OP_FLT		5'd6
`define FPU_OP_FLE		5'd7

// class mask
`define FPU_OP_CLASS	5'd8

// quiet NaN returned when no operand can be passed on
`define FPU_CANON_NAN	32'h7FC00000

`endif
